// File: verilog/enc_config.svh
// --------------------
// encoder interface config: widths, saturation value and queue depth
// --------------------

`ifndef ENC_CONFIG_SVH
`define ENC_CONFIG_SVH

// quarter timer and queue entry width
`define ENC_CNT_W 26

// saturation value, all ones of the timer width
`define ENC_CNT_MAX ({`ENC_CNT_W{1'b1}})

// number of latched quarter-cycle times
`define ENC_QUEUE_DEPTH 5

// signed position count width
`define ENC_POS_W 32

`endif

// File: verilog/enc_pkg.sv
// --------------------
// encoder interface types: edge kind, quarter flags, readout word
// --------------------

`include "enc_config.svh"

package enc_pkg;

    // most recent edge seen on the encoder lines
    typedef enum logic [1:0] {
        a_up = 2'd0,
        b_up = 2'd1,
        a_dn = 2'd2,
        b_dn = 2'd3
    } edge_kind_t;

    // per-quarter flags, ovf in the msb
    typedef struct packed {
        logic       ovf;   // latched time had saturated
        logic       dir;   // direction at the edge
        edge_kind_t kind;  // which edge closed the quarter
    } qtr_flags_t;

    // -------------------- readout views
    typedef struct packed {
        qtr_flags_t                flags;
        logic [27-`ENC_CNT_W:0]    zero;
        logic [`ENC_CNT_W-1:0]     count;
    } qtr_view_t;

    typedef struct packed {
        logic                      ovf;
        logic                      dir;      // current decoder dir
        logic [1:0]                enc_cnt;  // initial edges, sat at 3
        logic [27-`ENC_CNT_W:0]    zero;
        logic [`ENC_CNT_W-1:0]     count;
    } run_view_t;

    typedef struct packed {
        logic                      ovf;
        logic                      dir;         // dir of newest quarter
        logic                      dir_change;  // quarters 1..4 disagree
        logic [28-`ENC_CNT_W:0]    zero;
        logic [`ENC_CNT_W-1:0]     count;
    } per_view_t;

    // one 32-bit word, view chosen by reg_sel
    typedef union packed {
        qtr_view_t qtr;
        run_view_t run;
        per_view_t per;
    } enc_word_u;

endpackage

// File: verilog/quad_decoder.sv
// --------------------
// quadrature decoder: syncs A/B, tracks Gray state, direction and position
// --------------------

`timescale 1ns/1ps

`include "enc_config.svh"

module quad_decoder
    import enc_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        a,          // raw encoder line A
    input  logic                        b,          // raw encoder line B
    output logic                        edge_stb,   // one cycle per legal edge
    output edge_kind_t                  edge_kind,
    output logic                        dir,        // 1 = forward
    output logic signed [`ENC_POS_W-1:0] pos,
    output logic                        enc_err     // sticky, both lines moved
);

    logic [1:0] ab_meta;    // first sync stage, {a, b}
    logic [1:0] ab_sync;    // second sync stage
    logic [1:0] ab_prev;    // previous synced pair, the FSM state
    logic [1:0] cur_idx;    // Gray index of ab_sync
    logic [1:0] prev_idx;   // Gray index of ab_prev
    logic [1:0] step;       // index difference mod 4
    edge_kind_t next_kind;

    // AB order 00 -> 10 -> 11 -> 01 maps to index 0..3
    function automatic logic [1:0] gray_idx(input logic [1:0] ab);
        case (ab)
            2'b00:   gray_idx = 2'd0;
            2'b10:   gray_idx = 2'd1;
            2'b11:   gray_idx = 2'd2;
            default: gray_idx = 2'd3;  // 01
        endcase
    endfunction

    assign cur_idx  = gray_idx(ab_sync);
    assign prev_idx = gray_idx(ab_prev);
    assign step     = cur_idx - prev_idx;  // 1 fwd, 3 back, 2 illegal, 0 idle

    // edge kind from whichever line changed
    always_comb begin
        if (ab_sync[1] != ab_prev[1]) begin
            next_kind = ab_sync[1] ? a_up : a_dn;
        end else begin
            next_kind = ab_sync[0] ? b_up : b_dn;
        end
    end

    // --------------------
    // sync stages plus registered compare, strobe two edges after first sample
    always_ff @(posedge clk) begin
        if (rst) begin
            ab_meta   <= 2'b00;
            ab_sync   <= 2'b00;
            ab_prev   <= 2'b00;   // reset state AB = 00
            edge_stb  <= 1'b0;
            edge_kind <= a_up;
            dir       <= 1'b0;
            pos       <= '0;
            enc_err   <= 1'b0;
        end else begin
            ab_meta  <= {a, b};
            ab_sync  <= ab_meta;
            ab_prev  <= ab_sync;   // follows even on an illegal jump
            edge_stb <= 1'b0;

            case (step)
                2'd1: begin                // forward quarter
                    edge_stb  <= 1'b1;
                    edge_kind <= next_kind;
                    dir       <= 1'b1;
                    pos       <= pos + 1;
                end
                2'd3: begin                // backward quarter
                    edge_stb  <= 1'b1;
                    edge_kind <= next_kind;
                    dir       <= 1'b0;
                    pos       <= pos - 1;
                end
                2'd2: begin
                    // both lines in one sample, no way to tell direction
                    enc_err <= 1'b1;
                end
                default: begin
                    // no change this cycle
                end
            endcase
        end
    end

endmodule

// File: verilog/quarter_timer.sv
// --------------------
// quarter timer: saturating count of cycles since the last edge strobe
// --------------------

`timescale 1ns/1ps

`include "enc_config.svh"

module quarter_timer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  edge_stb,  // reload strobe from decoder
    output logic [`ENC_CNT_W-1:0] t_count,   // cycles in current quarter
    output logic                  t_ovf      // count has hit saturation
);

    logic at_max;      // count sits at the saturation value
    logic near_max;    // next increment reaches saturation

    assign at_max   = (t_count == `ENC_CNT_MAX);
    assign near_max = (t_count == `ENC_CNT_MAX - 1'b1);

    // --------------------
    // count runs from 1 after a strobe, so with strobes n cycles apart
    // the value seen at the next strobe is exactly n
    //
    // after reset nothing has been timed yet, so start saturated
    always_ff @(posedge clk) begin
        if (rst) begin
            t_count <= `ENC_CNT_MAX;
            t_ovf   <= 1'b1;
        end else if (edge_stb) begin
            t_count <= `ENC_CNT_W'(1);   // strobe cycle counts as the first
            t_ovf   <= 1'b0;
        end else if (!at_max) begin
            t_count <= t_count + 1'b1;
            t_ovf   <= near_max;         // flag together with the last step
        end else begin
            // hold at max, encoder too slow to measure
            t_ovf   <= 1'b1;
        end
    end

endmodule

// File: verilog/quarter_queue.sv
// --------------------
// shift queue of latched quarter times and their flags
// --------------------

`timescale 1ns/1ps

`include "enc_config.svh"

module quarter_queue
    import enc_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  edge_stb,   // shift strobe
    input  edge_kind_t            edge_kind,  // edge that closed the quarter
    input  logic                  dir,        // decoder dir at the strobe
    input  logic [`ENC_CNT_W-1:0] t_count,    // timer value to latch
    input  logic                  t_ovf,
    output logic [`ENC_CNT_W-1:0] q_count [1:`ENC_QUEUE_DEPTH],  // 1 newest
    output qtr_flags_t            q_flags [1:`ENC_QUEUE_DEPTH],
    output logic [1:0]            enc_cnt     // strobes seen, sat at 3
);

    qtr_flags_t new_flags;     // flags for the entry being latched

    assign new_flags = '{ovf: t_ovf, dir: dir, kind: edge_kind};

    // --------------------
    // latch the timer on the same edge it reloads
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i <= `ENC_QUEUE_DEPTH; i++) begin
                q_count[i] <= `ENC_CNT_MAX;
                // empty entry looks like an overflowed quarter
                q_flags[i] <= '{ovf: 1'b1, dir: 1'b0, kind: a_up};
            end
        end else if (edge_stb) begin
            q_count[1] <= t_count;
            q_flags[1] <= new_flags;
            // older entries move down one place, oldest falls off
            for (int i = 2; i <= `ENC_QUEUE_DEPTH; i++) begin
                q_count[i] <= q_count[i-1];
                q_flags[i] <= q_flags[i-1];
            end
        end
    end

    // --------------------
    // initial edge count
    // software ignores dir_change until enough quarters are real
    always_ff @(posedge clk) begin
        if (rst) begin
            enc_cnt <= 2'd0;
        end else if (edge_stb && (enc_cnt != 2'd3)) begin
            enc_cnt <= enc_cnt + 2'd1;
        end
    end

endmodule

// File: verilog/enc_word_format.sv
// --------------------
// readout formatter: full-cycle period, direction change, selected word
// --------------------

`timescale 1ns/1ps

`include "enc_config.svh"

module enc_word_format
    import enc_pkg::*;
(
    input  logic [`ENC_CNT_W-1:0] q_count [1:`ENC_QUEUE_DEPTH],
    input  qtr_flags_t            q_flags [1:`ENC_QUEUE_DEPTH],
    input  logic [`ENC_CNT_W-1:0] t_count,   // running time
    input  logic                  t_ovf,
    input  logic                  dir,       // current decoder dir
    input  logic [1:0]            enc_cnt,
    input  logic [2:0]            reg_sel,   // 0 per, 1 q1, 2 q5, 3 run
    output enc_word_u             rdata
);

    logic [`ENC_CNT_W+1:0] sum;        // 4 quarters, 2 guard bits
    logic                  any_ovf;    // an overflowed entry in 1..4
    logic                  sum_ovf;
    logic [`ENC_CNT_W-1:0] per_count;  // saturated period
    logic [3:0]            dir_all;    // dir flags of quarters 1..4
    logic                  dir_change;

    assign sum = {2'b00, q_count[1]} + {2'b00, q_count[2]}
               + {2'b00, q_count[3]} + {2'b00, q_count[4]};

    assign any_ovf   = q_flags[1].ovf | q_flags[2].ovf | q_flags[3].ovf | q_flags[4].ovf;
    assign sum_ovf   = any_ovf || (sum > {2'b00, `ENC_CNT_MAX});
    assign per_count = sum_ovf ? `ENC_CNT_MAX : sum[`ENC_CNT_W-1:0];

    assign dir_all    = {q_flags[1].dir, q_flags[2].dir, q_flags[3].dir, q_flags[4].dir};
    assign dir_change = (dir_all != 4'b0000) && (dir_all != 4'b1111);

    // -------------------- register select, unused fields stay zero
    always_comb begin
        rdata = '0;
        case (reg_sel)
            3'd0: begin    // full-cycle period
                rdata.per.ovf        = sum_ovf;
                rdata.per.dir        = q_flags[1].dir;
                rdata.per.dir_change = dir_change;
                rdata.per.count      = per_count;
            end
            3'd1: begin    // newest quarter
                rdata.qtr.flags = q_flags[1];
                rdata.qtr.count = q_count[1];
            end
            3'd2: begin    // oldest quarter
                rdata.qtr.flags = q_flags[`ENC_QUEUE_DEPTH];
                rdata.qtr.count = q_count[`ENC_QUEUE_DEPTH];
            end
            3'd3: begin    // time since last edge
                rdata.run.ovf     = t_ovf;
                rdata.run.dir     = dir;
                rdata.run.enc_cnt = enc_cnt;
                rdata.run.count   = t_count;
            end
            default: begin
                // unmapped selects read zero
            end
        endcase
    end

endmodule

// File: verilog/enc_top.sv
// --------------------
// encoder interface top: decoder, quarter timer, queue and readout
// --------------------

`timescale 1ns/1ps

`include "enc_config.svh"

module enc_top
    import enc_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         a,        // raw encoder lines
    input  logic                         b,
    input  logic [2:0]                   reg_sel,
    output enc_word_u                    rdata,
    output logic signed [`ENC_POS_W-1:0] pos,
    output logic                         dir,
    output logic                         enc_err
);

    // -------------------- internal nets
    logic                  edge_stb;
    edge_kind_t            edge_kind;
    logic [`ENC_CNT_W-1:0] t_count;
    logic                  t_ovf;
    logic [`ENC_CNT_W-1:0] q_count [1:`ENC_QUEUE_DEPTH];
    qtr_flags_t            q_flags [1:`ENC_QUEUE_DEPTH];
    logic [1:0]            enc_cnt;

    quad_decoder u_decoder (
        .clk       (clk),
        .rst       (rst),
        .a         (a),
        .b         (b),
        .edge_stb  (edge_stb),
        .edge_kind (edge_kind),
        .dir       (dir),
        .pos       (pos),
        .enc_err   (enc_err)
    );

    quarter_timer u_timer (
        .clk      (clk),
        .rst      (rst),
        .edge_stb (edge_stb),
        .t_count  (t_count),
        .t_ovf    (t_ovf)
    );

    // shifts on the same edge the timer reloads
    quarter_queue u_queue (
        .clk       (clk),
        .rst       (rst),
        .edge_stb  (edge_stb),
        .edge_kind (edge_kind),
        .dir       (dir),
        .t_count   (t_count),
        .t_ovf     (t_ovf),
        .q_count   (q_count),
        .q_flags   (q_flags),
        .enc_cnt   (enc_cnt)
    );

    enc_word_format u_format (
        .q_count (q_count),
        .q_flags (q_flags),
        .t_count (t_count),
        .t_ovf   (t_ovf),
        .dir     (dir),
        .enc_cnt (enc_cnt),
        .reg_sel (reg_sel),
        .rdata   (rdata)
    );

endmodule

// File: testbench/enc_tb.sv
// --------------------
// encoder interface testbench with a table of steps and a queue reference model
// every register read back after each edge
// --------------------

`timescale 1ns/1ps

`include "enc_config.svh"

module enc_tb
    import enc_pkg::*;
();

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         a;
    logic                         b;
    logic [2:0]                   reg_sel;
    enc_word_u                    rdata;
    logic signed [`ENC_POS_W-1:0] pos;
    logic                         dir;
    logic                         enc_err;

    enc_top uut (
        .clk     (clk),
        .rst     (rst),
        .a       (a),
        .b       (b),
        .reg_sel (reg_sel),
        .rdata   (rdata),
        .pos     (pos),
        .dir     (dir),
        .enc_err (enc_err)
    );

    always #10 clk = ~clk;   // 20 ns period

    int cyc = 0;             // rising edges since time zero
    always @(posedge clk) cyc <= cyc + 1;

    // -------------------- stimulus table
    // step 1 is forward, -1 backward, 2 moves both lines at once
    // spacing 0 picks a random one
    localparam int max_rows = 24;
    string                        row_name  [max_rows];
    int                           row_step  [max_rows];
    int                           row_space [max_rows];
    logic signed [`ENC_POS_W-1:0] row_pos   [max_rows];
    logic                         row_dir   [max_rows];
    logic                         row_err   [max_rows];
    int                           n_rows = 0;

    // -------------------- reference model state
    logic [`ENC_CNT_W-1:0] m_count [1:`ENC_QUEUE_DEPTH];  // 1 newest
    qtr_flags_t            m_flags [1:`ENC_QUEUE_DEPTH];
    int                    m_strobes = 0;       // legal edges so far
    logic                  m_dir = 1'b0;
    bit                    have_edge = 1'b0;
    int                    last_edge_cyc = 0;   // cyc at last legal pin change
    int                    gray_i = 0;          // index in 00,10,11,01
    logic [31:0]           rng = 32'd79306;

    int errors = 0;
    int rows_pass = 0;
    int rows_fail = 0;

    task automatic add_row(input string name, input int step, input int space,
                           input logic signed [`ENC_POS_W-1:0] p, input logic d,
                           input logic e);
        row_name[n_rows]  = name;
        row_step[n_rows]  = step;
        row_space[n_rows] = space;
        row_pos[n_rows]   = p;
        row_dir[n_rows]   = d;
        row_err[n_rows]   = e;
        n_rows++;
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // AB pair {a, b} for a position in the quadrature cycle
    function automatic logic [1:0] gray_pair(input int idx);
        case (idx)
            0:       return 2'b00;
            1:       return 2'b10;
            2:       return 2'b11;
            default: return 2'b01;
        endcase
    endfunction

    // name the edge by the line that moved and where it went
    function automatic edge_kind_t edge_kind_of(input logic [1:0] old_ab,
                                                input logic [1:0] new_ab);
        if (old_ab[1] != new_ab[1]) begin
            return new_ab[1] ? a_up : a_dn;
        end
        return new_ab[0] ? b_up : b_dn;
    endfunction

    task automatic latch_quarter(input logic [`ENC_CNT_W-1:0] cnt, input logic ovf,
                                 input logic d, input edge_kind_t kind);
        for (int i = `ENC_QUEUE_DEPTH; i >= 2; i--) begin
            m_count[i] = m_count[i-1];
            m_flags[i] = m_flags[i-1];
        end
        m_count[1] = cnt;
        m_flags[1] = '{ovf: ovf, dir: d, kind: kind};
    endtask

    // expected readout word; run view count holds the upper bound
    function automatic enc_word_u expected_word(input logic [2:0] sel);
        enc_word_u   w;
        logic [63:0] sum;
        logic        sat;
        logic [3:0]  d_all;
        w = '0;
        case (sel)
            3'd0: begin
                sum = 64'(m_count[1]) + 64'(m_count[2]) + 64'(m_count[3])
                    + 64'(m_count[4]);
                sat = m_flags[1].ovf | m_flags[2].ovf | m_flags[3].ovf
                    | m_flags[4].ovf | (sum > 64'(`ENC_CNT_MAX));
                d_all = {m_flags[1].dir, m_flags[2].dir, m_flags[3].dir, m_flags[4].dir};
                w.per.ovf        = sat;
                w.per.dir        = m_flags[1].dir;
                w.per.dir_change = (d_all != 4'b0000) && (d_all != 4'b1111);
                w.per.count      = sat ? `ENC_CNT_MAX : sum[`ENC_CNT_W-1:0];
            end
            3'd1: begin
                w.qtr.flags = m_flags[1];
                w.qtr.count = m_count[1];
            end
            3'd2: begin
                w.qtr.flags = m_flags[`ENC_QUEUE_DEPTH];
                w.qtr.count = m_count[`ENC_QUEUE_DEPTH];
            end
            3'd3: begin
                w.run.ovf     = (m_strobes == 0);
                w.run.dir     = m_dir;
                w.run.enc_cnt = (m_strobes >= 3) ? 2'd3 : 2'(m_strobes);
                w.run.count   = have_edge ? `ENC_CNT_W'(cyc - last_edge_cyc)
                                          : `ENC_CNT_MAX;
            end
            default: begin
                // unmapped select, all zero
            end
        endcase
        return w;
    endfunction

    // -------------------- compare tasks
    task automatic check_word(input string name, input logic [2:0] sel,
                              input enc_word_u exp, input enc_word_u act);
        bit bad;
        if (sel == 3'd3) begin
            bad = $isunknown(act) || (act.run.ovf !== exp.run.ovf)
                || (act.run.dir !== exp.run.dir) || (act.run.enc_cnt !== exp.run.enc_cnt)
                || (act.run.zero !== exp.run.zero);
            if (exp.run.ovf) begin
                bad = bad || (act.run.count !== exp.run.count);   // no edge yet, saturated
            end else begin
                bad = bad || (act.run.count > exp.run.count);     // bounded by elapsed time
            end
        end else begin
            bad = (act !== exp);
        end
        if (bad) begin
            errors++;
            $display("Mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_pos(input string name, input logic signed [`ENC_POS_W-1:0] exp,
                             input logic signed [`ENC_POS_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected %b actual %b", name, exp, act);
        end
    endtask

    // one select per falling edge, sampled mid low phase
    task automatic read_all(input string name);
        for (int s = 0; s < 8; s++) begin
            reg_sel = 3'(s);
            #5;
            check_word($sformatf("%s sel %0d", name, s), 3'(s), expected_word(3'(s)), rdata);
            @(negedge clk);
        end
    endtask

    // drive the pins for one step and advance the model
    task automatic drive_step(input int step);
        logic [1:0] old_ab;
        logic [1:0] new_ab;
        old_ab = gray_pair(gray_i);
        if (step == 2) begin
            gray_i = (gray_i + 2) % 4;        // both lines flip, queue holds
            new_ab = gray_pair(gray_i);
        end else begin
            gray_i = (gray_i + ((step > 0) ? 1 : 3)) % 4;
            new_ab = gray_pair(gray_i);
            m_dir  = (step > 0);
            if (have_edge) begin
                latch_quarter(`ENC_CNT_W'(cyc - last_edge_cyc), 1'b0, m_dir,
                              edge_kind_of(old_ab, new_ab));
            end else begin
                latch_quarter(`ENC_CNT_MAX, 1'b1, m_dir, edge_kind_of(old_ab, new_ab));
            end
            have_edge     = 1'b1;
            last_edge_cyc = cyc;
            m_strobes++;
        end
        {a, b} = new_ab;
    endtask

    task automatic wait_effect(input string name, input bit on_err,
                               input logic signed [`ENC_POS_W-1:0] exp_pos,
                               output bit got);
        got = 1'b0;
        for (int n = 0; n < 16 && !got; n++) begin
            @(negedge clk);
            if (on_err ? (enc_err === 1'b1) : (pos === exp_pos)) begin
                got = 1'b1;
            end
        end
        if (!got) begin
            errors++;
            if (on_err) $display("Timeout in %s: enc_err never went high", name);
            else        $display("Timeout in %s: pos never reached the expected value", name);
        end
    endtask

    task automatic report_row(input string name, input int err_before);
        if (errors == err_before) begin
            rows_pass++;
            $display("row %s ok", name);
        end else begin
            rows_fail++;
            $display("row %s failed", name);
        end
    endtask

    // --------------------
    initial begin
        int  spacing;
        int  err_before;
        bit  got;
        bit  aborted;
        rst     = 1'b1;
        a       = 1'b0;
        b       = 1'b0;
        reg_sel = 3'd0;
        aborted = 1'b0;
        for (int i = 1; i <= `ENC_QUEUE_DEPTH; i++) begin
            m_count[i] = `ENC_CNT_MAX;                      // empty looks saturated
            m_flags[i] = '{ovf: 1'b1, dir: 1'b0, kind: a_up};
        end

        add_row("fwd_first", 1, 5, 1, 1'b1, 1'b0);          // overflowed quarter
        add_row("fwd_2", 1, 10, 2, 1'b1, 1'b0);
        add_row("fwd_3", 1, 10, 3, 1'b1, 1'b0);
        add_row("fwd_4", 1, 10, 4, 1'b1, 1'b0);             // period still saturated
        add_row("fwd_5", 1, 10, 5, 1'b1, 1'b0);             // four real quarters
        add_row("fwd_6", 1, 10, 6, 1'b1, 1'b0);
        add_row("rev_1", -1, 12, 5, 1'b0, 1'b0);
        add_row("rev_2", -1, 12, 4, 1'b0, 1'b0);
        add_row("rev_3", -1, 12, 3, 1'b0, 1'b0);
        add_row("rev_4", -1, 12, 2, 1'b0, 1'b0);            // dir_change clears
        for (int i = 0; i < 4; i++) begin
            add_row($sformatf("rnd_fwd_%0d", i), 1, 0, 3 + i, 1'b1, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            add_row($sformatf("rnd_rev_%0d", i), -1, 0, 5 - i, 1'b0, 1'b0);
        end
        add_row("illegal", 2, 20, 2, 1'b0, 1'b1);
        add_row("after_err", 1, 10, 3, 1'b1, 1'b1);          // sticky error

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // reset state
        err_before = errors;
        check_pos("reset_state pos", 0, pos);
        check_flag("reset_state enc_err", 1'b0, enc_err);
        read_all("reset_state");
        report_row("reset_state", err_before);

        for (int r = 0; r < n_rows && !aborted; r++) begin
            err_before = errors;
            spacing = row_space[r];
            if (spacing == 0) begin
                rng     = xorshift32(rng);
                spacing = 3 + int'(rng % 32'd198);   // 3 to 200 cycles
            end
            repeat (spacing) @(negedge clk);
            drive_step(row_step[r]);
            wait_effect(row_name[r], row_step[r] == 2, row_pos[r], got);
            if (!got) begin
                aborted = 1'b1;
            end else begin
                @(negedge clk);                        // queue shifts one cycle later
                check_pos({row_name[r], " pos"}, row_pos[r], pos);
                check_flag({row_name[r], " dir"}, row_dir[r], dir);
                check_flag({row_name[r], " enc_err"}, row_err[r], enc_err);
                read_all(row_name[r]);
            end
            report_row(row_name[r], err_before);
        end

        $display("rows passed %0d, rows failed %0d, check errors %0d",
                 rows_pass, rows_fail, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+verilog
verilog/enc_pkg.sv
verilog/quad_decoder.sv
verilog/quarter_timer.sv
verilog/quarter_queue.sv
verilog/enc_word_format.sv
verilog/enc_top.sv
testbench/enc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the encoder interface testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
    -f files.f --top-module enc_tb -o enc_sim

./obj_dir/enc_sim > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    echo "simulation ended without a summary"
    exit 1
fi
exit 0
